/* unpack_pkg.sv */
/*
 * Vector operand unpack package
 * Shared widths, the element width encoding and the beat layout that travels
 * down the unpack pipeline.
 */
package unpack_pkg;

    // default read port and operand widths, overridden through the top level
    localparam int unsigned VREG_W = 64;
    localparam int unsigned OP_W = 32;

    // vector register address and opaque control tag widths
    localparam int unsigned VADDR_W = 5;
    localparam int unsigned CTRL_W = 8;

    // element width, encoded as in the vsew field of vtype
    typedef enum logic [1:0] {
        VSEW_8  = 2'b00,
        VSEW_16 = 2'b01,
        VSEW_32 = 2'b10
    } vsew_e;

    // per-operand unpack flags
    typedef struct packed {
        // fill the buffer from the read port
        logic load;
        // operand comes from a vector register, otherwise from xval
        logic vreg;
        // operand elements are half the element width
        logic narrow;
        // sign extend narrow elements instead of zero extending them
        logic sigext;
    } op_flags_t;

    // one instruction beat as accepted at the input handshake
    typedef struct packed {
        logic [CTRL_W-1:0] ctrl;
        vsew_e eew;
        op_flags_t data_flags;
        // only the load flag is meaningful for the mask operand
        op_flags_t mask_flags;
        logic [VADDR_W-1:0] data_vaddr;
        logic [VADDR_W-1:0] mask_vaddr;
        logic [31:0] xval;
    } beat_t;

endpackage

/* unpack_ctrl.sv */
/*
 * Unpack pipeline control
 * Holds the stage valid bits and beats of the two unpack stages, computes the
 * per-stage ready, drives the read addresses and issues the buffer enables.
 */
module unpack_ctrl (
    input  logic                                   clk_i,
    input  logic                                   async_rst_ni,

    input  logic                                   pipe_in_valid_i,
    output logic                                   pipe_in_ready_o,
    input  unpack_pkg::beat_t                      pipe_in_beat_i,

    output logic                                   pipe_out_valid_o,
    input  logic                                   pipe_out_ready_i,
    output logic [unpack_pkg::CTRL_W-1:0]          pipe_out_ctrl_o,

    output logic [1:0][unpack_pkg::VADDR_W-1:0]    vreg_rd_addr_o,

    output logic                                   data_load_en_o,
    output logic                                   data_shift_en_o,
    output logic                                   mask_load_en_o,
    output logic                                   mask_shift_en_o,

    output unpack_pkg::beat_t                      load_beat_o,
    output unpack_pkg::beat_t                      stage2_beat_o
);

    import unpack_pkg::*;

    logic  s1_valid_q;
    logic  s2_valid_q;
    beat_t s1_beat_q;
    beat_t s2_beat_q;

    logic  s1_adv;
    logic  s2_adv;
    logic  s1_fire;

    // neither stage stalls on its own, an empty stage is always ready
    assign s2_adv = pipe_out_ready_i | ~s2_valid_q;
    assign s1_adv = s2_adv | ~s1_valid_q;

    assign pipe_in_ready_o = s1_adv;

    // load stage holds a beat that moves on this cycle
    assign s1_fire = s1_valid_q & s2_adv;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_adv) begin
                s1_valid_q <= pipe_in_valid_i;
            end
            if (s2_adv) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    // beat payload only moves together with a valid beat
    always_ff @(posedge clk_i) begin
        if (s1_adv & pipe_in_valid_i) begin
            s1_beat_q <= pipe_in_beat_i;
        end
        if (s1_fire) begin
            s2_beat_q <= s1_beat_q;
        end
    end

    // data operand on port 0, mask on port 1, both addressed from the load stage
    assign vreg_rd_addr_o[0] = s1_beat_q.data_vaddr;
    assign vreg_rd_addr_o[1] = s1_beat_q.mask_vaddr;

    // a beat either refills a buffer or consumes its next section
    assign data_load_en_o  = s1_fire & s1_beat_q.data_flags.load;
    assign data_shift_en_o = s1_fire & ~s1_beat_q.data_flags.load;
    assign mask_load_en_o  = s1_fire & s1_beat_q.mask_flags.load;
    assign mask_shift_en_o = s1_fire & ~s1_beat_q.mask_flags.load;

    assign pipe_out_valid_o = s2_valid_q;
    assign pipe_out_ctrl_o  = s2_beat_q.ctrl;

    assign load_beat_o   = s1_beat_q;
    assign stage2_beat_o = s2_beat_q;

endmodule

/* operand_buffer.sv */
/*
 * Data operand buffer
 * Loads a full read port word and hands it out in operand-sized sections,
 * consuming half a section per beat for narrow operands.
 */
module operand_buffer #(
    parameter int unsigned VREG_W = unpack_pkg::VREG_W,
    parameter int unsigned OP_W   = unpack_pkg::OP_W
) (
    input  logic              clk_i,

    input  logic              load_en_i,
    input  logic              shift_en_i,
    input  logic              narrow_i,

    input  logic [VREG_W-1:0] vreg_data_i,
    output logic [OP_W-1:0]   op_raw_o
);

    localparam int unsigned HALF_W = OP_W / 2;

    logic [VREG_W-1:0] buf_q;
    logic [VREG_W-1:0] buf_shift;

    // consumed section drops out at the bottom, zeros come in at the top
    always_comb begin
        if (narrow_i) begin
            buf_shift = {{HALF_W{1'b0}}, buf_q[VREG_W-1:HALF_W]};
        end else begin
            buf_shift = {{OP_W{1'b0}}, buf_q[VREG_W-1:OP_W]};
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            buf_q <= vreg_data_i;
        end else if (shift_en_i) begin
            buf_q <= buf_shift;
        end
    end

    // current section is always the low end of the buffer
    assign op_raw_o = buf_q[OP_W-1:0];

endmodule

/* operand_extract.sv */
/*
 * Operand extraction
 * Widens narrow elements by sign or zero extension and broadcasts X register
 * values across all elements of the operand.
 */
module operand_extract #(
    parameter int unsigned OP_W = unpack_pkg::OP_W
) (
    input  logic [OP_W-1:0]     op_raw_i,
    input  unpack_pkg::beat_t   beat_i,
    output logic [OP_W-1:0]     op_data_o
);

    import unpack_pkg::*;

    logic [OP_W-1:0] narrow_data;
    logic [OP_W-1:0] bcast_data;
    logic            sigext;

    assign sigext = beat_i.data_flags.sigext;

    // narrow elements sit packed in the low half of the raw operand
    always_comb begin
        narrow_data = op_raw_i;
        case (beat_i.eew)
            VSEW_16: begin
                for (int j = 0; j < OP_W / 16; j++) begin
                    narrow_data[16*j +: 16] = {
                        {8{sigext & op_raw_i[8*j + 7]}},
                        op_raw_i[8*j +: 8]
                    };
                end
            end
            VSEW_32: begin
                for (int j = 0; j < OP_W / 32; j++) begin
                    narrow_data[32*j +: 32] = {
                        {16{sigext & op_raw_i[16*j + 15]}},
                        op_raw_i[16*j +: 16]
                    };
                end
            end
            default: ;
        endcase
    end

    // scalar operand, low element-width bits of xval in every element
    always_comb begin
        bcast_data = '0;
        case (beat_i.eew)
            VSEW_16: begin
                for (int j = 0; j < OP_W / 16; j++) begin
                    bcast_data[16*j +: 16] = beat_i.xval[15:0];
                end
            end
            VSEW_32: begin
                for (int j = 0; j < OP_W / 32; j++) begin
                    bcast_data[32*j +: 32] = beat_i.xval;
                end
            end
            default: begin
                for (int j = 0; j < OP_W / 8; j++) begin
                    bcast_data[8*j +: 8] = beat_i.xval[7:0];
                end
            end
        endcase
    end

    always_comb begin
        if (!beat_i.data_flags.vreg) begin
            op_data_o = bcast_data;
        end else if (beat_i.data_flags.narrow) begin
            op_data_o = narrow_data;
        end else begin
            op_data_o = op_raw_i;
        end
    end

endmodule

/* mask_unpack.sv */
/*
 * Mask operand unpack
 * Buffers the mask word, consumes one element bit per element of each
 * operand and expands element bits into a byte mask.
 */
module mask_unpack #(
    parameter int unsigned VREG_W = unpack_pkg::VREG_W,
    parameter int unsigned OP_W   = unpack_pkg::OP_W
) (
    input  logic                  clk_i,

    input  logic                  load_en_i,
    input  logic                  shift_en_i,
    input  unpack_pkg::vsew_e     load_eew_i,
    input  unpack_pkg::vsew_e     out_eew_i,

    input  logic [VREG_W-1:0]     vmask_data_i,
    output logic [OP_W/8-1:0]     mask_o
);

    import unpack_pkg::*;

    // element count of one operand at each element width
    localparam int unsigned ELEMS_8  = OP_W / 8;
    localparam int unsigned ELEMS_16 = OP_W / 16;
    localparam int unsigned ELEMS_32 = OP_W / 32;

    logic [VREG_W-1:0] mask_q;
    logic [VREG_W-1:0] mask_shift;

    // drop the element bits the previous operand used
    always_comb begin
        case (load_eew_i)
            VSEW_16: mask_shift = mask_q >> ELEMS_16;
            VSEW_32: mask_shift = mask_q >> ELEMS_32;
            default: mask_shift = mask_q >> ELEMS_8;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (load_en_i) begin
            mask_q <= vmask_data_i;
        end else if (shift_en_i) begin
            mask_q <= mask_shift;
        end
    end

    // one mask bit per byte, each element bit covers all bytes of its element
    always_comb begin
        mask_o = mask_q[ELEMS_8-1:0];
        case (out_eew_i)
            VSEW_16: begin
                for (int j = 0; j < ELEMS_16; j++) begin
                    mask_o[2*j +: 2] = {2{mask_q[j]}};
                end
            end
            VSEW_32: begin
                for (int j = 0; j < ELEMS_32; j++) begin
                    mask_o[4*j +: 4] = {4{mask_q[j]}};
                end
            end
            default: ;
        endcase
    end

endmodule

/* vreg_unpack_top.sv */
/*
 * Vector operand unpack pipeline
 * Two-stage pipeline returning one unpacked data operand and one byte mask
 * per accepted beat from the data and mask read ports.
 */
module vreg_unpack_top #(
    parameter int unsigned VREG_W = unpack_pkg::VREG_W,
    parameter int unsigned OP_W   = unpack_pkg::OP_W
) (
    input  logic                                   clk_i,
    input  logic                                   async_rst_ni,

    input  logic                                   pipe_in_valid_i,
    output logic                                   pipe_in_ready_o,
    input  unpack_pkg::beat_t                      pipe_in_beat_i,

    output logic                                   pipe_out_valid_o,
    input  logic                                   pipe_out_ready_i,
    output logic [unpack_pkg::CTRL_W-1:0]          pipe_out_ctrl_o,
    output logic [OP_W-1:0]                        pipe_out_data_o,
    output logic [OP_W/8-1:0]                      pipe_out_mask_o,

    output logic [1:0][unpack_pkg::VADDR_W-1:0]    vreg_rd_addr_o,
    input  logic [1:0][VREG_W-1:0]                 vreg_rd_data_i
);

    import unpack_pkg::*;

    beat_t           load_beat;
    beat_t           stage2_beat;
    logic            data_load_en;
    logic            data_shift_en;
    logic            mask_load_en;
    logic            mask_shift_en;
    logic [OP_W-1:0] op_raw;

    unpack_ctrl u_ctrl (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_valid_i  (pipe_in_valid_i),
        .pipe_in_ready_o  (pipe_in_ready_o),
        .pipe_in_beat_i   (pipe_in_beat_i),
        .pipe_out_valid_o (pipe_out_valid_o),
        .pipe_out_ready_i (pipe_out_ready_i),
        .pipe_out_ctrl_o  (pipe_out_ctrl_o),
        .vreg_rd_addr_o   (vreg_rd_addr_o),
        .data_load_en_o   (data_load_en),
        .data_shift_en_o  (data_shift_en),
        .mask_load_en_o   (mask_load_en),
        .mask_shift_en_o  (mask_shift_en),
        .load_beat_o      (load_beat),
        .stage2_beat_o    (stage2_beat)
    );

    // data operand is fed from read port 0
    operand_buffer #(
        .VREG_W (VREG_W),
        .OP_W   (OP_W)
    ) u_op_buf (
        .clk_i       (clk_i),
        .load_en_i   (data_load_en),
        .shift_en_i  (data_shift_en),
        .narrow_i    (load_beat.data_flags.narrow),
        .vreg_data_i (vreg_rd_data_i[0]),
        .op_raw_o    (op_raw)
    );

    operand_extract #(
        .OP_W (OP_W)
    ) u_op_extract (
        .op_raw_i  (op_raw),
        .beat_i    (stage2_beat),
        .op_data_o (pipe_out_data_o)
    );

    // mask operand is fed from read port 1
    mask_unpack #(
        .VREG_W (VREG_W),
        .OP_W   (OP_W)
    ) u_mask (
        .clk_i        (clk_i),
        .load_en_i    (mask_load_en),
        .shift_en_i   (mask_shift_en),
        .load_eew_i   (load_beat.eew),
        .out_eew_i    (stage2_beat.eew),
        .vmask_data_i (vreg_rd_data_i[1]),
        .mask_o       (pipe_out_mask_o)
    );

endmodule

/* tb_clock_gen.sv */
/*
 * Testbench clock and reset source
 * Free running clock and an active low reset held for a few cycles.
 */
module tb_clock_gen #(
    parameter int unsigned PERIOD     = 4,
    parameter int unsigned RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a rising edge so the first active cycle is a full one
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* tb_vreg_unpack.sv */
/*
 * Vector operand unpack pipeline testbench
 * Drives a table of beats against a vector register read model and checks
 * data, byte mask and ctrl order under random output back-pressure.
 */
module tb_vreg_unpack;

    import unpack_pkg::*;

    localparam int unsigned TB_VREG_W  = 64;
    localparam int unsigned TB_OP_W    = 32;
    localparam int          WAIT_LIMIT = 200;
    localparam int          RAND_ROWS  = 16;

    // data flag sets given as {load, vreg, narrow, sigext}
    localparam op_flags_t F_LD    = 4'b1100;
    localparam op_flags_t F_SH    = 4'b0100;
    localparam op_flags_t N_SX_LD = 4'b1111;
    localparam op_flags_t N_SX_SH = 4'b0111;
    localparam op_flags_t N_ZX_LD = 4'b1110;
    localparam op_flags_t N_ZX_SH = 4'b0110;
    localparam op_flags_t X_LD    = 4'b1000;

    logic                          clk_i;
    logic                          async_rst_ni;
    logic                          pipe_in_valid_i;
    logic                          pipe_in_ready_o;
    beat_t                         pipe_in_beat_i;
    logic                          pipe_out_valid_o;
    logic                          pipe_out_ready_i;
    logic [CTRL_W-1:0]             pipe_out_ctrl_o;
    logic [TB_OP_W-1:0]            pipe_out_data_o;
    logic [TB_OP_W/8-1:0]          pipe_out_mask_o;
    logic [1:0][VADDR_W-1:0]       vreg_rd_addr;
    logic [1:0][TB_VREG_W-1:0]     vreg_rd_data;

    string                 name_q[$];
    beat_t                 beat_q[$];
    logic [TB_OP_W-1:0]    exp_data_q[$];
    logic [TB_OP_W/8-1:0]  exp_mask_q[$];

    int   seed = 80;
    int   err_cnt = 0;
    int   pass_cnt = 0;
    int   fail_cnt = 0;
    logic timed_out = 1'b0;

    tb_clock_gen #(.PERIOD(4), .RST_CYCLES(3)) u_clk_gen (
        .clk_o   (clk_i),
        .rst_n_o (async_rst_ni)
    );

    vreg_unpack_top #(.VREG_W(TB_VREG_W), .OP_W(TB_OP_W)) dut (
        .clk_i            (clk_i),
        .async_rst_ni     (async_rst_ni),
        .pipe_in_valid_i  (pipe_in_valid_i),
        .pipe_in_ready_o  (pipe_in_ready_o),
        .pipe_in_beat_i   (pipe_in_beat_i),
        .pipe_out_valid_o (pipe_out_valid_o),
        .pipe_out_ready_i (pipe_out_ready_i),
        .pipe_out_ctrl_o  (pipe_out_ctrl_o),
        .pipe_out_data_o  (pipe_out_data_o),
        .pipe_out_mask_o  (pipe_out_mask_o),
        .vreg_rd_addr_o   (vreg_rd_addr),
        .vreg_rd_data_i   (vreg_rd_data)
    );

    // byte k of register a holds a*8+k
    function automatic logic [TB_VREG_W-1:0] vreg_word(input logic [VADDR_W-1:0] addr);
        logic [TB_VREG_W-1:0] w;
        int                   word_byte;
        for (int k = 0; k < TB_VREG_W / 8; k++) begin
            word_byte = int'(addr) * 8 + k;
            w[8*k +: 8] = word_byte[7:0];
        end
        return w;
    endfunction

    assign vreg_rd_data[0] = vreg_word(vreg_rd_addr[0]);
    assign vreg_rd_data[1] = vreg_word(vreg_rd_addr[1]);

    task automatic compare_value(input string test, input string field,
                                 input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %h, actual %h", test, field, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %s ok", test);
            pass_cnt++;
        end else begin
            $display("test %s failed", test);
            fail_cnt++;
        end
    endtask

    task automatic add_row(input string name, input vsew_e eew, input op_flags_t dflags,
                           input logic mload, input int dvaddr, input int mvaddr,
                           input logic [31:0] xval);
        beat_t bt;
        bt = '0;
        bt.ctrl = CTRL_W'(beat_q.size());
        bt.eew = eew;
        bt.data_flags = dflags;
        bt.mask_flags.load = mload;
        bt.data_vaddr = VADDR_W'(dvaddr);
        bt.mask_vaddr = VADDR_W'(mvaddr);
        bt.xval = xval;
        name_q.push_back(name);
        beat_q.push_back(bt);
    endtask

    task automatic build_table();
        int        r;
        vsew_e     eew_sel;
        op_flags_t f;
        add_row("full_load",        VSEW_8,  F_LD,    1'b1,  3,  3, 32'h0);
        add_row("full_shift",       VSEW_8,  F_SH,    1'b0,  3,  3, 32'h0);
        add_row("narrow_sext_pos",  VSEW_16, N_SX_LD, 1'b1,  5,  5, 32'h0);
        add_row("narrow_sext_next", VSEW_16, N_SX_SH, 1'b0,  5,  5, 32'h0);
        add_row("narrow_sext_neg",  VSEW_16, N_SX_LD, 1'b1, 20,  7, 32'h0);
        add_row("narrow_zext_neg",  VSEW_16, N_ZX_LD, 1'b0, 20,  7, 32'h0);
        add_row("narrow_zext_next", VSEW_16, N_ZX_SH, 1'b0, 20,  7, 32'h0);
        add_row("narrow_zext_pos",  VSEW_16, N_ZX_LD, 1'b0,  5,  7, 32'h0);
        add_row("narrow32_sext",    VSEW_32, N_SX_LD, 1'b1, 21,  9, 32'h0);
        add_row("narrow32_next",    VSEW_32, N_SX_SH, 1'b0, 21,  9, 32'h0);
        add_row("xbcast_e8",        VSEW_8,  X_LD,    1'b1,  2, 11, 32'h89abcdef);
        add_row("xbcast_e16",       VSEW_16, X_LD,    1'b0,  2, 11, 32'h1234fedc);
        add_row("xbcast_e32",       VSEW_32, X_LD,    1'b0,  2, 11, 32'hcafe0123);
        add_row("mask_e32_a",       VSEW_32, F_LD,    1'b1, 13, 11, 32'h0);
        add_row("mask_e32_b",       VSEW_32, F_LD,    1'b0, 14, 11, 32'h0);
        add_row("mask_e32_c",       VSEW_32, F_LD,    1'b0, 15, 11, 32'h0);
        add_row("mask_e32_d",       VSEW_32, F_LD,    1'b0, 16, 11, 32'h0);
        add_row("mask_e16_a",       VSEW_16, F_LD,    1'b1, 17, 15, 32'h0);
        add_row("mask_e16_b",       VSEW_16, F_LD,    1'b0, 18, 15, 32'h0);
        add_row("mask_e16_c",       VSEW_16, F_LD,    1'b0, 19, 15, 32'h0);
        add_row("mask_e8_a",        VSEW_8,  F_LD,    1'b1, 22, 29, 32'h0);
        add_row("mask_e8_b",        VSEW_8,  F_SH,    1'b0, 22, 29, 32'h0);
        // random beats use narrow only where an element can be widened
        for (int i = 0; i < RAND_ROWS; i++) begin
            r = $random(seed);
            eew_sel = (r[1:0] == 2'b11) ? VSEW_8 : vsew_e'(r[1:0]);
            f.load = r[2];
            f.vreg = r[3] | r[4];
            f.narrow = r[5] & (eew_sel != VSEW_8);
            f.sigext = r[6];
            add_row($sformatf("rand_%0d", i), eew_sel, f, r[7], int'(r[12:8]),
                    int'(r[17:13]), 32'($random(seed)));
        end
    endtask

    // expected results, computed bit by bit per element
    task automatic compute_expected();
        logic [TB_VREG_W-1:0] data_buf;
        logic [TB_VREG_W-1:0] mask_buf;
        logic [TB_OP_W-1:0]   raw;
        logic [TB_OP_W-1:0]   data;
        logic [TB_OP_W/8-1:0] mask;
        beat_t                bt;
        int                   ew;
        int                   elem;
        int                   pos;
        int                   half;
        data_buf = '0;
        mask_buf = '0;
        foreach (beat_q[i]) begin
            bt = beat_q[i];
            ew = 8 << int'(bt.eew);
            half = ew / 2;
            if (bt.data_flags.load) begin
                data_buf = vreg_word(bt.data_vaddr);
            end else if (bt.data_flags.narrow) begin
                data_buf = data_buf >> (TB_OP_W / 2);
            end else begin
                data_buf = data_buf >> TB_OP_W;
            end
            if (bt.mask_flags.load) begin
                mask_buf = vreg_word(bt.mask_vaddr);
            end else begin
                mask_buf = mask_buf >> (TB_OP_W / ew);
            end
            raw = data_buf[TB_OP_W-1:0];
            for (int n = 0; n < TB_OP_W; n++) begin
                elem = n / ew;
                pos = n % ew;
                if (!bt.data_flags.vreg) begin
                    data[n] = bt.xval[pos];
                end else if (bt.data_flags.narrow) begin
                    if (pos < half) begin
                        data[n] = raw[elem*half + pos];
                    end else begin
                        data[n] = bt.data_flags.sigext & raw[elem*half + half - 1];
                    end
                end else begin
                    data[n] = raw[n];
                end
            end
            for (int m = 0; m < TB_OP_W / 8; m++) begin
                mask[m] = mask_buf[m / (ew / 8)];
            end
            exp_data_q.push_back(data);
            exp_mask_q.push_back(mask);
        end
    endtask

    task automatic drive_beats();
        int idx;
        int wait_cnt;
        idx = 0;
        while (idx < beat_q.size() && !timed_out) begin
            @(posedge clk_i);
            pipe_in_valid_i <= 1'b1;
            pipe_in_beat_i <= beat_q[idx];
            wait_cnt = 0;
            @(negedge clk_i);
            while (!pipe_in_ready_o && !timed_out) begin
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    $display("timeout: beat of test %s was never accepted", name_q[idx]);
                    timed_out = 1'b1;
                end else begin
                    @(negedge clk_i);
                end
            end
            idx++;
        end
        @(posedge clk_i);
        pipe_in_valid_i <= 1'b0;
    endtask

    task automatic check_result(input int idx);
        int errs_before;
        errs_before = err_cnt;
        compare_value(name_q[idx], "ctrl", 64'(beat_q[idx].ctrl), 64'(pipe_out_ctrl_o));
        compare_value(name_q[idx], "data", 64'(exp_data_q[idx]), 64'(pipe_out_data_o));
        compare_value(name_q[idx], "mask", 64'(exp_mask_q[idx]), 64'(pipe_out_mask_o));
        report_test(name_q[idx], errs_before);
    endtask

    // results are sampled at the falling edge and taken at the next rising edge
    task automatic collect_results();
        int idx;
        int wait_cnt;
        int rnd;
        idx = 0;
        wait_cnt = 0;
        while (idx < beat_q.size() && !timed_out) begin
            @(posedge clk_i);
            rnd = $random(seed);
            pipe_out_ready_i <= (rnd[1:0] != 2'b00);
            @(negedge clk_i);
            if (pipe_out_valid_o && pipe_out_ready_i) begin
                check_result(idx);
                idx++;
                wait_cnt = 0;
            end else begin
                wait_cnt++;
                if (wait_cnt > WAIT_LIMIT) begin
                    $display("timeout: no result arrived for test %s", name_q[idx]);
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    initial begin
        int wait_cnt;
        int errs_before;
        pipe_in_valid_i = 1'b0;
        pipe_in_beat_i = '0;
        pipe_out_ready_i = 1'b0;
        build_table();
        compute_expected();
        wait_cnt = 0;
        while (!async_rst_ni && wait_cnt <= WAIT_LIMIT) begin
            @(posedge clk_i);
            wait_cnt++;
        end
        if (!async_rst_ni) begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end else begin
            @(negedge clk_i);
            errs_before = err_cnt;
            compare_value("reset", "out_valid", 64'(1'b0), 64'(pipe_out_valid_o));
            compare_value("reset", "in_ready", 64'(1'b1), 64'(pipe_in_ready_o));
            report_test("reset", errs_before);
            fork
                drive_beats();
                collect_results();
            join
            // the pipeline is empty once the last result has been taken
            if (!timed_out) begin
                @(posedge clk_i);
                @(negedge clk_i);
                errs_before = err_cnt;
                compare_value("drain", "out_valid", 64'(1'b0), 64'(pipe_out_valid_o));
                report_test("drain", errs_before);
            end
        end
        $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
unpack_pkg.sv
unpack_ctrl.sv
operand_buffer.sv
operand_extract.sv
mask_unpack.sv
vreg_unpack_top.sv
tb_clock_gen.sv
tb_vreg_unpack.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the unpack pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_vreg_unpack -f project.f -o tb_sim \
    > build.log 2>&1 &&
    ./obj_dir/tb_sim > sim.log 2>&1 ||
    { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
